// File: bench/spi_trace.txt
# ctrl_mode len divider ss_mask tx_data miso_data expected_rx   (all hex)
# ctrl_mode has go clear; len 00 means 64 bits
34 08 0003 01 00000000000000a5 000000000000003c 000000000000003c
2a 10 0001 02 0000000000001234 000000000000beef 000000000000beef
44 0c 0002 81 0000000000000abc 000000000000ffed 0000000000000fed
5c 20 0000 10 00000000deadbeef 1234567887654321 0000000087654321
32 00 0001 ff 0123456789abcdef fedcba9876543210 fedcba9876543210
0c 05 0004 04 0000000000000013 00000000000000ff 000000000000001f
22 28 0002 20 000000aa55aa55aa ffffffffffffffff 000000ffffffffff
6a 01 0001 40 0000000000000001 0000000000000001 0000000000000001

// File: files.f
src/spi_pkg.sv
src/spi_xfer_if.sv
src/spi_clk_gen.sv
src/spi_shift_reg.sv
src/spi_wb_regs.sv
src/spi_master_top.sv
bench/spi_asserts.sv
bench/spi_checker.sv
bench/spi_tb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module spi_tb -o Vspi_tb
	out="$$(./obj_dir/Vspi_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module spi_tb

clean:
	rm -rf obj_dir

// File: bench/spi_tb.sv
`timescale 1ns/1ps

module spi_tb;
  import spi_pkg::*;

  localparam int ACK_LIMIT  = 20;
  localparam int DONE_LIMIT = 5000;   // clk cycles

  logic                clk;
  logic                rst;
  logic                i_stb;
  logic                i_we;
  bus_addr_t           i_adr;
  bus_word_t           i_dat;
  bus_word_t           o_dat;
  logic                o_ack;
  logic                o_int;
  logic                o_sclk;
  logic                o_mosi;
  logic                i_miso;
  logic [SS_COUNT-1:0] o_ss_n;
  char_t               mosi_seen;   // bits captured by the slave model

  spi_master_top u_dut (.*);

  spi_checker u_chk (.clk(clk), .rst(rst), .o_int(o_int));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic finish_run();
    u_chk.summary();
    if (u_chk.n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic stop_run(input string what);
    u_chk.report_problem(what);
    finish_run();
  endtask

  // one four-phase bus cycle, entered and left just after a falling edge
  task automatic bus_cycle(input logic we, input int adr, input bus_word_t dat,
                           input int hold, output bus_word_t rd);
    int n;
    i_stb = 1'b1;
    i_we  = we;
    i_adr = bus_addr_t'(adr);
    i_dat = dat;
    n = 0;
    @(negedge clk);
    while (!o_ack && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!o_ack) stop_run("no acknowledge for a bus request");
    u_chk.compare("o_ack extra latency", 0, n);
    repeat (hold) @(negedge clk);   // slow master keeps the strobe up
    rd    = o_dat;
    i_stb = 1'b0;
    n = 0;
    @(negedge clk);
    while (o_ack && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (o_ack) stop_run("o_ack stayed high after i_stb dropped");
    repeat ($urandom % 3) @(negedge clk);
  endtask

  task automatic bus_write(input int adr, input bus_word_t dat);
    bus_word_t unused;
    bus_cycle(1'b1, adr, dat, 0, unused);
  endtask

  task automatic check_reg(input string name, input int adr, input logic [63:0] exp);
    bus_word_t rd;
    bus_cycle(1'b0, adr, '0, $urandom % 3, rd);
    u_chk.compare(name, exp, 64'(rd));
  endtask

  task automatic check_idle_pads(input logic [6:0] mode, input logic [7:0] ss);
    u_chk.compare("o_sclk idle", 64'(mode[CTRL_INV_CLK]), 64'(o_sclk));
    u_chk.compare("o_ss_n idle", mode[CTRL_ASS] ? 64'hff : 64'(8'(~ss)), 64'(o_ss_n));
  endtask

  // serial slave, acts on the falling clk edge after each sclk change
  task automatic serial_slave(input logic [6:0] mode, input int len, input logic [15:0] div,
                              input logic [7:0] ss, input char_t miso);
    logic prev;
    logic cur;
    logic pad_prev;
    int   bits_rx;
    int   bits_mo;
    int   cyc;
    int   last_rise;
    prev      = 1'b0;
    pad_prev  = o_sclk;
    bits_rx   = 0;
    bits_mo   = 0;
    cyc       = 0;
    last_rise = -1;
    mosi_seen = '0;
    i_miso    = miso[mode[CTRL_LSB] ? 0 : len-1];   // first bit before the first sample
    while ((bits_rx < len || bits_mo < len) && cyc < 2*(div+1)*(len+4) + 200) begin
      @(negedge clk);
      cyc++;
      cur = o_sclk ^ mode[CTRL_INV_CLK];
      if (o_sclk && !pad_prev && bits_rx < len) begin
        if (last_rise >= 0) u_chk.compare("sclk period", 2*(div+1), cyc - last_rise);
        last_rise = cyc;
      end
      if (cur != prev) begin
        // the final sampling edge also ends tip
        if (bits_rx < len && !(cur != mode[CTRL_RX_NEG] && bits_rx == len-1)) begin
          u_chk.compare("o_ss_n active", 64'(8'(~ss)), 64'(o_ss_n));
        end
        if (cur == mode[CTRL_TX_NEG] && bits_mo < len) begin  // edge opposite to mosi drive
          mosi_seen[mode[CTRL_LSB] ? bits_mo : len-1-bits_mo] = o_mosi;
          bits_mo++;
        end
        if (cur == !mode[CTRL_RX_NEG] && bits_rx < len) begin  // master just sampled
          bits_rx++;
          if (bits_rx < len) i_miso = miso[mode[CTRL_LSB] ? bits_rx : len-1-bits_rx];
        end
      end
      prev     = cur;
      pad_prev = o_sclk;
    end
    if (bits_rx < len || bits_mo < len) stop_run("serial clock stopped before the last bit");
  endtask

  task automatic wait_done(input logic ie);
    bus_word_t rd;
    int        n;
    n  = 0;
    rd = '1;
    if (ie) begin
      while (!o_int && n < DONE_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (!o_int) stop_run("no interrupt at the end of the transfer");
    end else begin
      while (rd[CTRL_GO] && n < DONE_LIMIT / 8) begin
        bus_cycle(1'b0, ADR_CTRL, '0, 0, rd);
        n++;
      end
      if (rd[CTRL_GO]) stop_run("go bit never cleared");
    end
  endtask

  task automatic run_transfer(input logic [6:0] mode, input logic [6:0] len_f,
                              input logic [15:0] div, input logic [7:0] ss, input char_t tx,
                              input char_t miso, input char_t exp_rx, input string name);
    int    len;
    char_t mask;
    len  = (len_f == 0) ? MAX_CHAR : int'(len_f);
    mask = (len == MAX_CHAR) ? '1 : ((char_t'(1) << len) - 1'b1);
    u_chk.begin_test(name);
    u_chk.int_allowed = mode[CTRL_IE];
    bus_write(ADR_DIVIDER, 32'(div));
    bus_write(ADR_SS, 32'(ss));
    bus_write(ADR_BIT_COUNT, 32'(len_f));
    bus_write(ADR_TX0, tx[63:32]);
    bus_write(ADR_TX1, tx[31:0]);
    bus_write(ADR_CTRL, 32'(mode));
    check_idle_pads(mode, ss);
    fork
      serial_slave(mode, len, div, ss, miso);
      begin
        bus_write(ADR_CTRL, 32'(mode) | 32'h1);
        bus_write(ADR_DIVIDER, 32'(div ^ 16'h00ff));   // busy, dropped
        wait_done(mode[CTRL_IE]);
      end
    join
    u_chk.compare("o_int at end", 64'(mode[CTRL_IE]), 64'(o_int));
    check_reg("ctrl after transfer", ADR_CTRL, 64'(mode));
    u_chk.compare("o_int after read", 0, 64'(o_int));
    check_reg("rx0", ADR_RX0, 64'(exp_rx[63:32]));
    check_reg("rx1", ADR_RX1, 64'(exp_rx[31:0]));
    u_chk.compare("mosi bits", tx & mask, mosi_seen);
    check_reg("divider after busy write", ADR_DIVIDER, 64'(div));
    check_idle_pads(mode, ss);
    u_chk.end_test();
  endtask

  task automatic reg_test();
    u_chk.begin_test("registers");
    check_reg("divider reset", ADR_DIVIDER, 100);
    bus_write(ADR_DIVIDER, 32'h1234);
    check_reg("divider", ADR_DIVIDER, 32'h1234);
    bus_write(ADR_SS, 32'ha5);
    check_reg("ss", ADR_SS, 32'ha5);
    bus_write(ADR_BIT_COUNT, 32'h2c);
    check_reg("bit count", ADR_BIT_COUNT, 32'h2c);
    bus_write(ADR_CTRL, 32'h7e);
    check_reg("ctrl", ADR_CTRL, 32'h7e);
    check_reg("clock rate", ADR_CLK_RATE, 64'(CLK_RATE_HZ));
    check_reg("max bits", ADR_MAX_BITS, 64);
    check_reg("unmapped", 12, 0);
    bus_write(ADR_CTRL, 32'h0);
    u_chk.end_test();
  endtask

  initial begin
    int          fd;
    int          n;
    int          test_no;
    string       line;
    logic [6:0]  mode;
    logic [6:0]  len_f;
    logic [15:0] div;
    logic [7:0]  ss;
    char_t       tx;
    char_t       miso;
    char_t       exp_rx;
    rst    = 1'b1;
    i_stb  = 1'b0;
    i_we   = 1'b0;
    i_adr  = '0;
    i_dat  = '0;
    i_miso = 1'b0;
    void'($urandom(32'h22a3_ea9b));
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reg_test();
    fd = $fopen("bench/spi_trace.txt", "r");
    if (fd == 0) stop_run("cannot open bench/spi_trace.txt");
    test_no = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 1 || line.getc(0) == 8'h23) continue;   // blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h", mode, len_f, div, ss, tx, miso, exp_rx);
      if (n != 7) continue;
      test_no++;
      run_transfer(mode, len_f, div, ss, tx, miso, exp_rx, $sformatf("transfer %0d", test_no));
    end
    $fclose(fd);
    if (test_no == 0) u_chk.report_problem("trace file held no transfers");
    finish_run();
  end

endmodule

// File: bench/spi_checker.sv
`timescale 1ns/1ps

module spi_checker (
  input logic clk,
  input logic rst,
  input logic o_int
);

  int    n_tests     = 0;
  int    n_checks    = 0;
  int    n_errors    = 0;
  int    test_errors = 0;
  logic  int_allowed = 1'b0;   // set by the tb from the ie bit
  logic  int_flagged = 1'b0;
  string test_name   = "";

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    int_flagged = 1'b0;
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      test_errors++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_problem(input string what);
    n_errors++;
    test_errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic end_test();
    n_tests++;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d error(s)", test_name, test_errors);
    end
  endtask

  task automatic summary();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
  endtask

  // interrupt watch, one report per test
  always @(negedge clk) begin
    if (!rst && !int_allowed && o_int && !int_flagged) begin
      int_flagged = 1'b1;
      report_problem("o_int went high while interrupts were disabled");
    end
  end

endmodule

// File: bench/spi_asserts.sv
`timescale 1ns/1ps

module spi_asserts (
  input logic                         clk,
  input logic                         rst,
  input logic                         i_stb,
  input logic                         o_ack,
  input logic [spi_pkg::SS_COUNT-1:0] o_ss_n,
  input logic                         tip,
  input logic                         ass
);

  // ack only answers a strobe
  ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
    $rose(o_ack) |-> $past(i_stb))
    else $error("o_ack rose without i_stb");

  ack_held: assert property (@(posedge clk) disable iff (rst)
    (o_ack && i_stb) |=> o_ack)
    else $error("o_ack dropped while i_stb was high");

  // automatic select releases all pads between transfers
  ss_idle: assert property (@(posedge clk) disable iff (rst)
    (ass && !tip) |-> (o_ss_n == '1))
    else $error("o_ss_n active outside a transfer in automatic mode");

endmodule

bind spi_master_top spi_asserts u_asserts (
  .clk    (clk),
  .rst    (rst),
  .i_stb  (i_stb),
  .o_ack  (o_ack),
  .o_ss_n (o_ss_n),
  .tip    (xfer.tip),
  .ass    (u_regs.ctrl[spi_pkg::CTRL_ASS])
);

// File: src/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top (
  input  logic                          clk,
  input  logic                          rst,
  // bus slave port
  input  logic                          i_stb,
  input  logic                          i_we,
  input  spi_pkg::bus_addr_t            i_adr,
  input  spi_pkg::bus_word_t            i_dat,
  output spi_pkg::bus_word_t            o_dat,
  output logic                          o_ack,
  output logic                          o_int,
  // serial pads
  output logic                          o_sclk,
  output logic                          o_mosi,
  input  logic                          i_miso,
  output logic [spi_pkg::SS_COUNT-1:0]  o_ss_n
);
  import spi_pkg::*;

  spi_xfer_if xfer ();

  div_t divider;
  logic sclk;      // internal serial clock, before polarity
  logic pos_edge;
  logic neg_edge;

  spi_clk_gen u_clk_gen (
    .clk        (clk),
    .rst        (rst),
    .i_go       (xfer.go),
    .i_tip      (xfer.tip),
    .i_divider  (divider),
    .o_sclk     (sclk),
    .o_pos_edge (pos_edge),
    .o_neg_edge (neg_edge)
  );

  spi_shift_reg u_shift (
    .clk        (clk),
    .rst        (rst),
    .i_pos_edge (pos_edge),
    .i_neg_edge (neg_edge),
    .i_miso     (i_miso),
    .o_mosi     (o_mosi),
    .xfer       (xfer.shifter)
  );

  spi_wb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .i_stb      (i_stb),
    .i_we       (i_we),
    .i_adr      (i_adr),
    .i_dat      (i_dat),
    .o_dat      (o_dat),
    .o_ack      (o_ack),
    .o_int      (o_int),
    .i_pos_edge (pos_edge),
    .o_divider  (divider),
    .o_sclk_pad (o_sclk),
    .o_ss_n     (o_ss_n),
    .i_sclk     (sclk),
    .xfer       (xfer.regs)
  );

endmodule

// File: src/spi_wb_regs.sv
`timescale 1ns/1ps

module spi_wb_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_stb,
  input  logic                          i_we,
  input  spi_pkg::bus_addr_t            i_adr,
  input  spi_pkg::bus_word_t            i_dat,
  output spi_pkg::bus_word_t            o_dat,
  output logic                          o_ack,
  output logic                          o_int,
  input  logic                          i_pos_edge,
  output spi_pkg::div_t                 o_divider,
  output logic                          o_sclk_pad,
  output logic [spi_pkg::SS_COUNT-1:0]  o_ss_n,
  input  logic                          i_sclk,
  spi_xfer_if.regs                      xfer
);
  import spi_pkg::*;

  logic [CTRL_INV_CLK:0] ctrl;
  div_t                  divider;
  logic [SS_COUNT-1:0]   ss;
  char_len_t             char_len;
  bus_word_t             tx_word [RX_WORDS];   // word 0 is the high word
  bus_word_t             rx_word [RX_WORDS];
  bus_word_t             rd_val;
  logic                  req;
  logic                  wr_ok;
  logic                  xfer_end;

  assign req      = i_stb && !o_ack;           // new request, ack not yet up
  assign wr_ok    = req && i_we && !xfer.tip;  // busy writes are acked and dropped
  // final sample, on a rising sclk unless sampling on the falling one
  assign xfer_end = xfer.last && (xfer.rx_neg || i_pos_edge);

  // transfer command
  assign xfer.go     = ctrl[CTRL_GO];
  assign xfer.rx_neg = ctrl[CTRL_RX_NEG];
  assign xfer.tx_neg = ctrl[CTRL_TX_NEG];
  assign xfer.lsb    = ctrl[CTRL_LSB];
  assign xfer.len    = char_len;
  assign o_divider   = divider;

  for (genvar w = 0; w < RX_WORDS; w++) begin : g_words
    assign xfer.tx_data[w*32 +: 32] = tx_word[RX_WORDS-1-w];
    assign rx_word[RX_WORDS-1-w]    = xfer.rx_data[w*32 +: 32];
  end

  // pads
  assign o_sclk_pad = ctrl[CTRL_INV_CLK] ? ~i_sclk : i_sclk;
  assign o_ss_n     = ~(ss & {SS_COUNT{xfer.tip || !ctrl[CTRL_ASS]}});

  // read decode
  always_comb begin
    case (i_adr)
      ADR_CTRL:      rd_val = bus_word_t'(ctrl);
      ADR_CLK_RATE:  rd_val = bus_word_t'(CLK_RATE_HZ);
      ADR_DIVIDER:   rd_val = bus_word_t'(divider);
      ADR_SS:        rd_val = bus_word_t'(ss);
      ADR_BIT_COUNT: rd_val = bus_word_t'(char_len);
      ADR_MAX_BITS:  rd_val = bus_word_t'(MAX_CHAR);
      ADR_RX0:       rd_val = rx_word[0];
      ADR_RX1:       rd_val = rx_word[1];
      default:       rd_val = '0;       // unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack    <= 1'b0;
      o_int    <= 1'b0;
      ctrl     <= '0;
      divider  <= div_t'(100);
      ss       <= '0;
      char_len <= '0;
    end else begin
      // four-phase handshake
      if (req) begin
        o_ack <= 1'b1;
      end else if (!i_stb) begin
        o_ack <= 1'b0;
      end

      // set wins over the clearing ack
      if (xfer_end && ctrl[CTRL_IE]) begin
        o_int <= 1'b1;
      end else if (req) begin
        o_int <= 1'b0;
      end

      if (xfer_end) begin
        ctrl[CTRL_GO] <= 1'b0;
      end

      if (wr_ok) begin
        case (i_adr)
          ADR_CTRL:      ctrl     <= i_dat[CTRL_INV_CLK:0];
          ADR_DIVIDER:   divider  <= i_dat[$bits(div_t)-1:0];
          ADR_SS:        ss       <= i_dat[SS_COUNT-1:0];
          ADR_BIT_COUNT: char_len <= i_dat[$bits(char_len_t)-1:0];
          default: ;
        endcase
      end
    end
  end

  // read data and tx words
  always_ff @(posedge clk) begin
    if (req) begin
      o_dat <= rd_val;
    end
    if (wr_ok && (i_adr == ADR_TX0)) begin
      tx_word[0] <= i_dat;
    end
    if (wr_ok && (i_adr == ADR_TX1)) begin
      tx_word[1] <= i_dat;
    end
  end

endmodule

// File: src/spi_shift_reg.sv
`timescale 1ns/1ps

module spi_shift_reg (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_pos_edge,
  input  logic        i_neg_edge,
  input  logic        i_miso,
  output logic        o_mosi,
  spi_xfer_if.shifter xfer
);
  import spi_pkg::*;

  shift_state_t state;
  char_t        tx_q;
  char_t        rx_q;
  logic [$clog2(MAX_CHAR)-1:0] tx_pos;     // next bit to drive
  logic [$clog2(MAX_CHAR)-1:0] rx_pos;     // next bit to sample
  logic [$clog2(MAX_CHAR)-1:0] first_pos;
  char_len_t    len_eff;
  char_len_t    len_m1;
  char_len_t    rx_left;                   // samples still to take
  logic         drive_edge;
  logic         sample_edge;
  logic         start;

  // one bit position along the shift order
  function automatic logic [$clog2(MAX_CHAR)-1:0] step(
    input logic [$clog2(MAX_CHAR)-1:0] pos,
    input logic                        up
  );
    return up ? pos + 1'b1 : pos - 1'b1;
  endfunction

  assign len_eff     = (xfer.len == '0) ? char_len_t'(MAX_CHAR) : xfer.len;
  assign len_m1      = len_eff - 1'b1;
  assign first_pos   = xfer.lsb ? '0 : len_m1[$clog2(MAX_CHAR)-1:0];
  assign drive_edge  = xfer.tx_neg ? i_neg_edge : i_pos_edge;
  assign sample_edge = xfer.rx_neg ? i_neg_edge : i_pos_edge;
  assign start       = (state == IDLE) && xfer.go;

  assign xfer.tip     = (state == SHIFT);
  assign xfer.last    = (state == SHIFT) && sample_edge && (rx_left == char_len_t'(1));
  assign xfer.rx_data = rx_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      o_mosi  <= 1'b0;
      rx_left <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (xfer.go) begin
            state   <= SHIFT;
            rx_left <= len_eff;
            // falling-edge drive puts the first bit out before the first rise
            if (xfer.tx_neg) begin
              o_mosi <= xfer.tx_data[first_pos];
            end
          end
        end
        SHIFT: begin
          if (drive_edge) begin
            o_mosi <= tx_q[tx_pos];
          end
          if (sample_edge) begin
            rx_left <= rx_left - 1'b1;
            if (rx_left == char_len_t'(1)) begin
              state <= DONE;
            end
          end
        end
        DONE: begin
          if (!xfer.go) begin  // wait for go to clear so no restart
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // shift data and bit pointers
  always_ff @(posedge clk) begin
    if (start) begin
      tx_q   <= xfer.tx_data;
      rx_q   <= '0;            // bits above len read as zero
      rx_pos <= first_pos;
      tx_pos <= xfer.tx_neg ? step(first_pos, xfer.lsb) : first_pos;
    end else if (state == SHIFT) begin
      if (drive_edge) begin
        tx_pos <= step(tx_pos, xfer.lsb);
      end
      if (sample_edge) begin
        rx_q[rx_pos] <= i_miso;
        rx_pos       <= step(rx_pos, xfer.lsb);
      end
    end
  end

endmodule

// File: src/spi_clk_gen.sv
`timescale 1ns/1ps

module spi_clk_gen (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_go,
  input  logic          i_tip,
  input  spi_pkg::div_t i_divider,
  output logic          o_sclk,
  output logic          o_pos_edge,
  output logic          o_neg_edge
);
  import spi_pkg::*;

  div_t cnt;     // clk cycles left in this half period
  logic expire;

  // sclk toggles on the edge where the count runs out
  assign expire     = i_tip && (cnt == '0);
  assign o_pos_edge = expire && !o_sclk;
  assign o_neg_edge = expire && o_sclk;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt    <= '0;
      o_sclk <= 1'b0;
    end else if (!i_tip) begin
      // idle: sclk low, first rising edge right after tip when go is set
      cnt    <= i_go ? '0 : i_divider;
      o_sclk <= 1'b0;
    end else if (expire) begin
      cnt    <= i_divider;    // half period is divider+1 cycles
      o_sclk <= ~o_sclk;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

// File: src/spi_xfer_if.sv
`timescale 1ns/1ps

interface spi_xfer_if;
  import spi_pkg::*;

  // command, from the register block
  logic      go;
  char_len_t len;
  logic      lsb;
  logic      rx_neg;
  logic      tx_neg;
  char_t     tx_data;

  // result, from the shifter
  logic      tip;      // transfer in progress
  logic      last;     // final sample strobe
  char_t     rx_data;

  modport regs (
    output go, len, lsb, rx_neg, tx_neg, tx_data,
    input  tip, last, rx_data
  );

  modport shifter (
    input  go, len, lsb, rx_neg, tx_neg, tx_data,
    output tip, last, rx_data
  );

endinterface

// File: src/spi_pkg.sv
package spi_pkg;

  // sizes
  localparam int MAX_CHAR    = 64;
  localparam int RX_WORDS    = MAX_CHAR / 32;
  localparam int SS_COUNT    = 8;
  localparam int CLK_RATE_HZ = 10_000_000;

  // register map, word addresses
  localparam int ADR_CTRL      = 0;
  localparam int ADR_CLK_RATE  = 1;
  localparam int ADR_DIVIDER   = 2;
  localparam int ADR_SS        = 3;
  localparam int ADR_BIT_COUNT = 4;
  localparam int ADR_MAX_BITS  = 5;
  localparam int ADR_RX0       = 6;   // rx bits 63:32
  localparam int ADR_RX1       = 7;   // rx bits 31:0
  localparam int ADR_TX0       = 8;   // tx bits 63:32
  localparam int ADR_TX1       = 9;   // tx bits 31:0

  // control register bits
  localparam int CTRL_GO      = 0;
  localparam int CTRL_RX_NEG  = 1;   // sample miso on falling sclk
  localparam int CTRL_TX_NEG  = 2;   // drive mosi on falling sclk
  localparam int CTRL_LSB     = 3;
  localparam int CTRL_IE      = 4;
  localparam int CTRL_ASS     = 5;
  localparam int CTRL_INV_CLK = 6;   // highest ctrl bit

  typedef logic [31:0]         bus_word_t;
  typedef logic [31:0]         bus_addr_t;
  typedef logic [MAX_CHAR-1:0] char_t;
  typedef logic [6:0]          char_len_t;  // 0 means MAX_CHAR
  typedef logic [15:0]         div_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } shift_state_t;

endpackage
